/* source/dram_mon_pkg.sv */
// DRAM chip-select monitor constants and types shared by all blocks
`default_nettype none

package dram_mon_pkg;

   // Channel and rank geometry
   localparam int NUM_CH    = 4;
   localparam int NUM_RANK  = 2;                        // Chip selects per channel
   localparam int RANK_W    = $clog2(NUM_RANK);

   // Controller queue position
   localparam int QUE_POS_W = 5;
   localparam logic [QUE_POS_W-1:0] ISSUE_POS = 5'h0a;  // Slot where a command issues

   // Rank switch spacing, in cycles
   localparam int RANK_GAP  = 6;
   localparam int GAP_CNT_W = $clog2(RANK_GAP + 1);     // Counter saturates at RANK_GAP

   // Error accounting
   localparam int ERR_CNT_W = 8;
   localparam int HIT_CNT_W = $clog2(2 * NUM_CH + 1);   // Up to two errors per channel

   typedef logic [NUM_RANK-1:0]  cs_l_t;                // Active low
   typedef logic [QUE_POS_W-1:0] que_pos_t;
   typedef logic [RANK_W-1:0]    rank_t;
   typedef logic [GAP_CNT_W-1:0] gap_cnt_t;

   typedef cs_l_t    [NUM_CH-1:0] ch_cs_l_t;
   typedef que_pos_t [NUM_CH-1:0] ch_que_pos_t;
   typedef logic     [NUM_CH-1:0] ch_flags_t;           // One bit per channel

   typedef logic [ERR_CNT_W-1:0] err_cnt_t;
   typedef logic [HIT_CNT_W-1:0] hit_cnt_t;

endpackage : dram_mon_pkg

`default_nettype wire

/* source/cs_check_if.sv */
// Per-channel link carrying chip-select samples in and error pulses out
`timescale 1ns/1ps
`default_nettype none

interface cs_check_if;

   import dram_mon_pkg::*;

   que_pos_t que_pos;      // Controller queue position, level
   cs_l_t    cs_l;         // Pad chip selects, active low

   logic     err_overlap;  // One-cycle pulse
   logic     err_early;    // One-cycle pulse

   // Sampling side
   modport check (
      input  que_pos,
      input  cs_l,
      output err_overlap,
      output err_early
   );

   // Log only needs the error pulses
   modport log (
      input  err_overlap,
      input  err_early
   );

endinterface : cs_check_if

`default_nettype wire

/* source/rank_switch_checker.sv */
// Flags rank overlap and too-early rank switches on one DRAM channel at issue slots
`timescale 1ns/1ps
`default_nettype none

module rank_switch_checker (
   input  logic     clk,
   input  logic     rst_l,
   cs_check_if.check chk
);

   import dram_mon_pkg::*;

   logic     issue;        // Sample this cycle
   logic     multi_sel;    // More than one rank low
   logic     one_sel;      // Exactly one rank low
   rank_t    sel_rank;     // Index of the low chip select
   logic     early_hit;

   logic     last_vld;
   rank_t    last_rank;
   gap_cnt_t gap_cnt;      // Cycles since last single-rank select

   assign issue     = (chk.que_pos == ISSUE_POS);
   assign multi_sel = ($countones(~chk.cs_l) > 1);
   assign one_sel   = ($countones(~chk.cs_l) == 1);

   // Encode the selected rank, only meaningful when one_sel is set
   always_comb begin
      sel_rank = '0;
      for (int r = 0; r < NUM_RANK; r++) begin
         if (!chk.cs_l[r]) begin
            sel_rank = rank_t'(r);
         end
      end
   end

   // Different rank inside the gap window
   assign early_hit = one_sel && last_vld && (sel_rank != last_rank) &&
                      (gap_cnt < RANK_GAP);

   always_ff @(posedge clk) begin
      if (rst_l) begin
         chk.err_overlap <= 1'b0;
         chk.err_early   <= 1'b0;
         last_vld        <= 1'b0;
         last_rank       <= '0;
         gap_cnt         <= gap_cnt_t'(RANK_GAP);   // Nothing recent out of reset
      end else begin
         chk.err_overlap <= issue && multi_sel;
         chk.err_early   <= issue && early_hit;

         if (issue && one_sel) begin
            last_vld  <= 1'b1;
            last_rank <= sel_rank;
            gap_cnt   <= gap_cnt_t'(1);             // One cycle gone by the next edge
         end else begin
            if (gap_cnt < RANK_GAP) begin
               gap_cnt <= gap_cnt + 1'b1;
            end
            if (issue && multi_sel) begin
               last_vld <= 1'b0;                     // Overlap wipes the history
            end
         end
      end
   end

   // The two error kinds come from exclusive select counts
   a_err_excl : assert property (
      @(posedge clk) disable iff (rst_l)
      !(chk.err_overlap && chk.err_early)
   ) else $error("overlap and early error pulsed together");

   // Any error must trace back to an issue slot one cycle earlier
   a_err_after_issue : assert property (
      @(posedge clk) disable iff (rst_l)
      (chk.err_overlap || chk.err_early) |-> $past(chk.que_pos == ISSUE_POS)
   ) else $error("error pulse without a preceding issue slot");

endmodule : rank_switch_checker

`default_nettype wire

/* source/cs_error_log.sv */
// Gathers chip-select errors from all channels into sticky flags and a saturating count
`timescale 1ns/1ps
`default_nettype none

module cs_error_log (
   input  logic                   clk,
   input  logic                   rst_l,
   input  logic                   err_clr,
   cs_check_if.log                chk [dram_mon_pkg::NUM_CH],
   output dram_mon_pkg::ch_flags_t overlap_flags,
   output dram_mon_pkg::ch_flags_t early_flags,
   output dram_mon_pkg::err_cnt_t  err_count,
   output logic                   err_new
);

   import dram_mon_pkg::*;

   ch_flags_t            ovl_hit;    // Overlap pulses this cycle
   ch_flags_t            early_hit;  // Early switch pulses this cycle
   hit_cnt_t             hit_num;
   logic [ERR_CNT_W:0]   cnt_sum;    // One extra bit catches the carry
   logic                 any_hit;

   // Interface arrays need a constant index
   for (genvar g = 0; g < NUM_CH; g++) begin : g_gather
      assign ovl_hit[g]   = chk[g].err_overlap;
      assign early_hit[g] = chk[g].err_early;
   end

   assign hit_num = hit_cnt_t'($countones({ovl_hit, early_hit}));
   assign any_hit = |{ovl_hit, early_hit};
   assign cnt_sum = {1'b0, err_count} + (ERR_CNT_W + 1)'(hit_num);

   always_ff @(posedge clk) begin
      if (rst_l) begin
         overlap_flags <= '0;
         early_flags   <= '0;
         err_count     <= '0;
         err_new       <= 1'b0;
      end else if (err_clr) begin
         overlap_flags <= '0;        // Clear wins over arriving errors
         early_flags   <= '0;
         err_count     <= '0;
         err_new       <= 1'b0;
      end else begin
         overlap_flags <= overlap_flags | ovl_hit;
         early_flags   <= early_flags | early_hit;
         err_new       <= any_hit;
         if (cnt_sum[ERR_CNT_W]) begin
            err_count <= '1;         // Saturate
         end else begin
            err_count <= cnt_sum[ERR_CNT_W-1:0];
         end
      end
   end

   // Count only drops after a clear or reset
   a_cnt_monotonic : assert property (
      @(posedge clk) disable iff (rst_l)
      (err_count < $past(err_count)) |-> $past(err_clr || rst_l)
   ) else $error("error count dropped without clear");

   // A new error leaves a sticky flag behind
   a_new_has_flag : assert property (
      @(posedge clk) disable iff (rst_l)
      err_new |-> |{overlap_flags, early_flags}
   ) else $error("err_new without any flag set");

endmodule : cs_error_log

`default_nettype wire

/* source/dram_cs_mon.sv */
// Four-channel DRAM chip-select monitor top with per-channel checkers and a shared log
`timescale 1ns/1ps
`default_nettype none

module dram_cs_mon (
   input  logic                       clk,
   input  logic                       rst_l,
   input  dram_mon_pkg::ch_que_pos_t  que_pos,    // Per-channel controller queue position
   input  dram_mon_pkg::ch_cs_l_t     pad_cs_l,   // Per-channel pad chip selects
   input  logic                       err_clr,
   output dram_mon_pkg::ch_flags_t    overlap_flags,
   output dram_mon_pkg::ch_flags_t    early_flags,
   output dram_mon_pkg::err_cnt_t     err_count,
   output logic                       err_new
);

   import dram_mon_pkg::*;

   cs_check_if ch_if [NUM_CH] ();

   // One checker per channel
   for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
      assign ch_if[g].que_pos = que_pos[g];
      assign ch_if[g].cs_l    = pad_cs_l[g];

      rank_switch_checker u_chk (
         .clk   (clk),
         .rst_l (rst_l),
         .chk   (ch_if[g])
      );
   end

   // Flags and count update one cycle after the checker pulses
   cs_error_log u_log (
      .clk           (clk),
      .rst_l         (rst_l),
      .err_clr       (err_clr),
      .chk           (ch_if),
      .overlap_flags (overlap_flags),
      .early_flags   (early_flags),
      .err_count     (err_count),
      .err_new       (err_new)
   );

endmodule : dram_cs_mon

`default_nettype wire

/* test/tb_dram_cs_mon.sv */
// Testbench for the four-channel DRAM chip-select monitor with reference model and LFSR stimulus
`timescale 1ns/1ps
`default_nettype none

module tb_dram_cs_mon;

   import dram_mon_pkg::*;

   localparam int MAX_CYCLES = 6000;          // Twice the expected run length

   logic        clk;
   logic        rst_l;
   ch_que_pos_t que_pos;
   ch_cs_l_t    pad_cs_l;
   logic        err_clr;
   ch_flags_t   overlap_flags;
   ch_flags_t   early_flags;
   err_cnt_t    err_count;
   logic        err_new;

   // Reference model state
   logic        m_vld [NUM_CH];
   int          m_rank [NUM_CH];
   int          m_last [NUM_CH];             // Cycle of the last single-rank select
   int          cyc;
   ch_flags_t   pend_ovl, pend_early;         // Checker stage
   ch_flags_t   exp_ovl, exp_early;           // Log stage
   err_cnt_t    exp_count;
   logic        exp_new;

   logic [15:0] lfsr_q;
   int          fail_cnt;
   int          tests_ok, tests_bad;
   int          cycle_cnt;
   int          fails_at;

   dram_cs_mon dram_cs_mon_inst (
      .clk           (clk),
      .rst_l         (rst_l),
      .que_pos       (que_pos),
      .pad_cs_l      (pad_cs_l),
      .err_clr       (err_clr),
      .overlap_flags (overlap_flags),
      .early_flags   (early_flags),
      .err_count     (err_count),
      .err_new       (err_new)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
   function automatic logic [7:0] take_bits(input int n);
      logic [7:0] v;
      logic       fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         v      = {v[6:0], fb};
      end
      return v;
   endfunction

   task automatic report_mismatch(input string sig, input logic [7:0] got,
                                  input logic [7:0] exp);
      fail_cnt++;
      $display("FAILED %s got 0x%h expected 0x%h at %0t", sig, got, exp, $time);
   endtask

   task automatic cycle_in(input ch_que_pos_t qp, input ch_cs_l_t cs);
      @(posedge clk);
      #1;
      que_pos  = qp;
      pad_cs_l = cs;
   endtask

   task automatic idle(input int n);
      repeat (n) cycle_in('0, '1);
   endtask

   // Issue slot on one channel only
   task automatic sample_ch(input int ch, input cs_l_t cs);
      ch_que_pos_t qp;
      ch_cs_l_t    cl;
      qp     = '0;
      cl     = '1;
      qp[ch] = ISSUE_POS;
      cl[ch] = cs;
      cycle_in(qp, cl);
   endtask

   task automatic end_test(input string name);
      if (fail_cnt == fails_at) begin
         tests_ok++;
         $display("Test %s: ok", name);
      end else begin
         tests_bad++;
         $display("Test %s: %0d mismatches", name, fail_cnt - fails_at);
      end
      fails_at = fail_cnt;
   endtask

   // Model of the issue-slot rules and the error log, two stages deep
   always @(posedge clk) begin : ref_model
      int hits;
      int sum;
      int rank;
      if (rst_l) begin
         cyc = 0;
         pend_ovl = '0;
         pend_early = '0;
         exp_ovl = '0;
         exp_early = '0;
         exp_count = '0;
         exp_new = 1'b0;
         for (int c = 0; c < NUM_CH; c++) begin
            m_vld[c] = 1'b0;
         end
      end else begin
         if (err_clr) begin
            exp_ovl   = '0;
            exp_early = '0;
            exp_count = '0;
            exp_new   = 1'b0;
         end else begin
            hits      = $countones({pend_ovl, pend_early});
            sum       = exp_count + hits;
            exp_ovl   = exp_ovl | pend_ovl;
            exp_early = exp_early | pend_early;
            exp_count = (sum > (1 << ERR_CNT_W) - 1) ? '1 : err_cnt_t'(sum);
            exp_new   = (hits != 0);
         end
         for (int c = 0; c < NUM_CH; c++) begin
            pend_ovl[c]   = 1'b0;
            pend_early[c] = 1'b0;
            if (que_pos[c] == ISSUE_POS) begin
               if (pad_cs_l[c] == 2'b00) begin
                  pend_ovl[c] = 1'b1;
                  m_vld[c]    = 1'b0;
               end else if (pad_cs_l[c] != 2'b11) begin
                  rank          = (pad_cs_l[c] == 2'b10) ? 0 : 1;
                  pend_early[c] = m_vld[c] && (m_rank[c] != rank) &&
                                  (cyc - m_last[c] < RANK_GAP);
                  m_vld[c]  = 1'b1;
                  m_rank[c] = rank;
                  m_last[c] = cyc;
               end
            end
         end
         cyc++;
      end
   end

   a_ovl : assert property (@(posedge clk) disable iff (rst_l) overlap_flags == exp_ovl)
      else report_mismatch("overlap_flags", $sampled(overlap_flags), $sampled(exp_ovl));
   a_early : assert property (@(posedge clk) disable iff (rst_l) early_flags == exp_early)
      else report_mismatch("early_flags", $sampled(early_flags), $sampled(exp_early));
   a_count : assert property (@(posedge clk) disable iff (rst_l) err_count == exp_count)
      else report_mismatch("err_count", $sampled(err_count), $sampled(exp_count));
   a_new : assert property (@(posedge clk) disable iff (rst_l) err_new == exp_new)
      else report_mismatch("err_new", $sampled(err_new), $sampled(exp_new));

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("*** FAILED ***");
         $finish;
      end
   end

   initial begin
      ch_que_pos_t qp;
      ch_cs_l_t    cs;
      lfsr_q = 16'd18011;
      fail_cnt = 0;
      fails_at = 0;
      tests_ok = 0;
      tests_bad = 0;
      cycle_cnt = 0;
      rst_l = 1'b1;
      que_pos = '0;
      pad_cs_l = '1;
      err_clr = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      rst_l = 1'b0;

      // 1: quiet after reset, cs toggles outside issue slots
      assert (err_count == 0) else report_mismatch("err_count", err_count, 8'h00);
      assert (overlap_flags == 0)
         else report_mismatch("overlap_flags", overlap_flags, 8'h00);
      assert (early_flags == 0) else report_mismatch("early_flags", early_flags, 8'h00);
      assert (!err_new) else report_mismatch("err_new", err_new, 8'h00);
      for (int i = 0; i < 50; i++) begin
         for (int c = 0; c < NUM_CH; c++) begin
            qp[c] = que_pos_t'(take_bits(QUE_POS_W));
            if (qp[c] == ISSUE_POS) begin
               qp[c] = qp[c] ^ 5'h01;
            end
            cs[c] = cs_l_t'(take_bits(NUM_RANK));
         end
         cycle_in(qp, cs);
      end
      idle(3);
      assert (err_count == 0) else report_mismatch("err_count", err_count, 8'h00);
      end_test("reset_and_idle");

      // 2: overlap on channel 1
      sample_ch(1, 2'b00);
      idle(3);
      assert (overlap_flags == 4'b0010)
         else report_mismatch("overlap_flags", overlap_flags, 8'h02);
      assert (early_flags == 0) else report_mismatch("early_flags", early_flags, 8'h00);
      assert (err_count == 1) else report_mismatch("err_count", err_count, 8'h01);
      end_test("overlap");

      // 3: rank switch 3 cycles apart, then 6 apart, then same rank
      sample_ch(2, 2'b10);
      idle(2);
      sample_ch(2, 2'b01);
      idle(3);
      assert (early_flags == 4'b0100) else report_mismatch("early_flags", early_flags, 8'h04);
      err_clr = 1'b1;
      idle(1);
      err_clr = 1'b0;
      idle(8);
      sample_ch(2, 2'b10);
      idle(5);
      sample_ch(2, 2'b01);
      sample_ch(2, 2'b01);
      idle(1);
      sample_ch(2, 2'b01);
      idle(3);
      assert (early_flags == 0) else report_mismatch("early_flags", early_flags, 8'h00);
      end_test("early_switch");

      // 4: several channels at once, then errors masked by clear
      err_clr = 1'b1;
      idle(1);
      err_clr = 1'b0;
      cycle_in({4{ISSUE_POS}}, {2'b11, 2'b00, 2'b10, 2'b00});
      idle(3);
      assert (err_count == 2) else report_mismatch("err_count", err_count, 8'h02);
      err_clr = 1'b1;
      cycle_in({4{ISSUE_POS}}, {4{2'b00}});
      idle(3);
      err_clr = 1'b0;
      idle(2);
      assert (err_count == 0) else report_mismatch("err_count", err_count, 8'h00);
      assert (overlap_flags == 0)
         else report_mismatch("overlap_flags", overlap_flags, 8'h00);
      end_test("multi_channel_clear");

      // 5: 280 errors saturate the count
      repeat (70) cycle_in({4{ISSUE_POS}}, {4{2'b00}});
      idle(3);
      assert (err_count == 8'hff) else report_mismatch("err_count", err_count, 8'hff);
      end_test("saturation");

      // 6: random traffic against the model
      for (int i = 0; i < 2000; i++) begin
         for (int c = 0; c < NUM_CH; c++) begin
            if (take_bits(1) != 0) qp[c] = ISSUE_POS;
            else qp[c] = que_pos_t'(take_bits(QUE_POS_W));
            cs[c] = cs_l_t'(take_bits(NUM_RANK));
         end
         cycle_in(qp, cs);
         err_clr = (take_bits(5) == 0);
      end
      err_clr = 1'b0;
      idle(3);
      end_test("random");

      $display("Tests: %0d passed, %0d failed, %0d mismatches", tests_ok, tests_bad, fail_cnt);
      if (tests_bad == 0 && fail_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule : tb_dram_cs_mon

`default_nettype wire

/* sim.f */
source/dram_mon_pkg.sv
source/cs_check_if.sv
source/rank_switch_checker.sv
source/cs_error_log.sv
source/dram_cs_mon.sv
test/tb_dram_cs_mon.sv

/* Bender.yml */
package:
  name: dram_cs_mon

dependencies: {}

sources:
  # Shared package and channel interface
  - files:
      - source/dram_mon_pkg.sv
      - source/cs_check_if.sv

  # Checkers, error log and top level
  - files:
      - source/rank_switch_checker.sv
      - source/cs_error_log.sv
      - source/dram_cs_mon.sv

  # Testbench
  - target: test
    files:
      - test/tb_dram_cs_mon.sv
